/* hw/rs_pkg.sv */
package rs_pkg;

    parameter int preg_idx_width = 6;
    parameter int br_mask_width  = 4;

    // Functional units per class
    parameter int num_fu_alu   = 2;
    parameter int num_fu_mult  = 1;
    parameter int num_fu_ld    = 1;
    parameter int num_fu_store = 1;
    parameter int num_fu_br    = 1;

    parameter int default_rs_depth       = 8;
    parameter int default_dispatch_width = 2;

    typedef enum logic [2:0] {
        alu_inst,
        mult_inst,
        ld_inst,
        store_inst,
        br_inst
    } fu_type_t;

    typedef enum logic [1:0] {
        br_none,
        br_clear,
        br_squash
    } br_task_t;

    // One bit per unresolved branch
    typedef logic [br_mask_width-1:0] br_mask_t;

    typedef struct packed {
        logic [preg_idx_width-1:0] tag;
        logic                      ready;
    } src_tag_t;

    typedef struct packed {
        logic                      valid;
        logic [preg_idx_width-1:0] tag;
    } cdb_packet_t;

    typedef struct packed {
        logic                      valid;
        fu_type_t                  fu_type;
        logic [7:0]                func;
        logic [preg_idx_width-1:0] dest_tag;
        src_tag_t                  src1;
        src_tag_t                  src2;
        br_mask_t                  br_mask;
    } dispatch_packet_t;

    // Station entry, valid marks an occupied slot
    typedef struct packed {
        logic                      valid;
        fu_type_t                  fu_type;
        logic [7:0]                func;
        logic [preg_idx_width-1:0] dest_tag;
        src_tag_t                  src1;
        src_tag_t                  src2;
        br_mask_t                  br_mask;
    } rs_packet_t;

endpackage

/* hw/psel_gen.sv */
`timescale 1ns/100ps

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]            req,
    output logic [REQS-1:0][WIDTH-1:0]  gnt_bus,
    output logic [WIDTH-1:0]            gnt,
    output logic                        empty
);

    int grant_total;

    // Grant k takes the k-th lowest request
    always_comb begin
        int k;
        gnt_bus = '0;
        k = 0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i] && k < REQS) begin
                gnt_bus[k][i] = 1'b1;
                k++;
            end
        end
    end

    always_comb begin
        gnt = '0;
        grant_total = 0;
        for (int k = 0; k < REQS; k++) begin
            gnt = gnt | gnt_bus[k];
            grant_total = grant_total + $countones(gnt_bus[k]);
        end
    end

    assign empty = ~|req;

    // Grants are disjoint, so their bits add up to the merged vector
    grant_overlap_check: assert final (grant_total == $countones(gnt))
        else $error("psel_gen: overlapping grants %b", gnt_bus);

endmodule

/* hw/rs_issue_select.sv */
`timescale 1ns/100ps

module rs_issue_select #(
    parameter int DEPTH  = 8,
    parameter int NUM_FU = 2
) (
    input  logic [DEPTH-1:0]              inst_req,
    input  logic [NUM_FU-1:0]             fu_busy,
    output logic [NUM_FU-1:0][DEPTH-1:0]  fu_issued_insts,
    output logic [$clog2(NUM_FU+1)-1:0]   num_issued,
    output logic [DEPTH-1:0]              all_issued
);

    logic [NUM_FU-1:0][DEPTH-1:0]  inst_gnt_bus;
    logic [NUM_FU-1:0][NUM_FU-1:0] fu_gnt_bus;
    logic [NUM_FU-1:0]             unit_used;

    psel_gen #(.WIDTH(DEPTH), .REQS(NUM_FU)) inst_sel (
        .req     (inst_req),
        .gnt_bus (inst_gnt_bus),
        .gnt     (),
        .empty   ()
    );

    psel_gen #(.WIDTH(NUM_FU), .REQS(NUM_FU)) unit_sel (
        .req     (~fu_busy),
        .gnt_bus (fu_gnt_bus),
        .gnt     (),
        .empty   ()
    );

    // k-th oldest ready slot goes to the k-th idle unit
    always_comb begin
        fu_issued_insts = '0;
        num_issued = '0;
        for (int k = 0; k < NUM_FU; k++) begin
            for (int u = 0; u < NUM_FU; u++) begin
                if (fu_gnt_bus[k][u]) begin
                    fu_issued_insts[u] = inst_gnt_bus[k];
                end
            end
            if (|inst_gnt_bus[k] && |fu_gnt_bus[k]) begin
                num_issued = num_issued + 1'b1;
            end
        end
    end

    always_comb begin
        all_issued = '0;
        for (int u = 0; u < NUM_FU; u++) begin
            unit_used[u] = |fu_issued_insts[u];
            all_issued = all_issued | fu_issued_insts[u];
        end
    end

    busy_unit_check: assert final ((unit_used & fu_busy) == '0)
        else $error("rs_issue_select: busy unit granted, busy %b", fu_busy);

endmodule

/* hw/dispatch_admit.sv */
`timescale 1ns/100ps

module dispatch_admit
    import rs_pkg::*;
#(
    parameter int N = 2
) (
    input  dispatch_packet_t [N-1:0]  dispatch_in,
    input  logic [$clog2(N+1)-1:0]    open_entries,
    output dispatch_packet_t [N-1:0]  admitted,
    output logic [$clog2(N+1)-1:0]    num_accept
);

    // In-order prefix, first refused valid slot blocks the rest
    always_comb begin
        logic stop;
        admitted = dispatch_in;
        num_accept = '0;
        stop = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (dispatch_in[i].valid) begin
                if (!stop && num_accept < open_entries) begin
                    num_accept = num_accept + 1'b1;
                end else begin
                    stop = 1'b1;
                    admitted[i].valid = 1'b0;
                end
            end
        end
    end

endmodule

/* hw/rs.sv */
`timescale 1ns/100ps

module rs
    import rs_pkg::*;
#(
    parameter int DEPTH = 8,
    parameter int N     = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    input  dispatch_packet_t [N-1:0]          admitted,
    input  logic [$clog2(N+1)-1:0]            num_accept,
    input  cdb_packet_t [N-1:0]               cdb_in,
    input  br_mask_t                          br_id,
    input  br_task_t                          br_task,
    input  logic [num_fu_alu-1:0]             fu_alu_busy,
    input  logic [num_fu_mult-1:0]            fu_mult_busy,
    input  logic [num_fu_ld-1:0]              fu_ld_busy,
    input  logic [num_fu_store-1:0]           fu_store_busy,
    input  logic [num_fu_br-1:0]              fu_br_busy,
    output rs_packet_t [num_fu_alu-1:0]       issued_alu,
    output rs_packet_t [num_fu_mult-1:0]      issued_mult,
    output rs_packet_t [num_fu_ld-1:0]        issued_ld,
    output rs_packet_t [num_fu_store-1:0]     issued_store,
    output rs_packet_t [num_fu_br-1:0]        issued_br,
    output logic [$clog2(N+1)-1:0]            open_entries
);

    localparam int CNT_W = $clog2(DEPTH+1);
    localparam int ACC_W = $clog2(N+1);

    rs_packet_t [DEPTH-1:0] entries, next_entries;

    logic [DEPTH-1:0] valid_vec, squash_hit, free_slots, all_issued;
    logic [DEPTH-1:0] alu_req, mult_req, ld_req, store_req, br_req;
    logic [DEPTH-1:0] alu_all, mult_all, ld_all, store_all, br_all;
    logic [N-1:0][DEPTH-1:0] alloc_bus;
    logic [DEPTH-1:0] alloc_gnt;
    logic [CNT_W-1:0] num_occupied, num_empty;

    logic [num_fu_alu-1:0][DEPTH-1:0]   alu_bus;
    logic [num_fu_mult-1:0][DEPTH-1:0]  mult_bus;
    logic [num_fu_ld-1:0][DEPTH-1:0]    ld_bus;
    logic [num_fu_store-1:0][DEPTH-1:0] store_bus;
    logic [num_fu_br-1:0][DEPTH-1:0]    br_bus;

    // Picks the selected entry and applies this cycle's branch outcome
    function automatic rs_packet_t issue_pick(input logic [DEPTH-1:0] sel,
                                              input rs_packet_t [DEPTH-1:0] ents,
                                              input br_mask_t id,
                                              input br_task_t task_in);
        rs_packet_t pkt;
        pkt = '0;
        for (int j = 0; j < DEPTH; j++) begin
            if (sel[j]) begin
                pkt = ents[j];
            end
        end
        if (task_in == br_squash && (pkt.br_mask & id) != '0) begin
            pkt = '0;
        end else if (task_in == br_clear) begin
            pkt.br_mask = pkt.br_mask & ~id;
        end
        return pkt;
    endfunction

    always_comb begin
        alu_req = '0;
        mult_req = '0;
        ld_req = '0;
        store_req = '0;
        br_req = '0;
        for (int i = 0; i < DEPTH; i++) begin
            valid_vec[i] = entries[i].valid;
            squash_hit[i] = entries[i].valid && br_task == br_squash
                            && (entries[i].br_mask & br_id) != '0;
            if (entries[i].valid && entries[i].src1.ready && entries[i].src2.ready) begin
                case (entries[i].fu_type)
                    alu_inst:   alu_req[i] = 1'b1;
                    mult_inst:  mult_req[i] = 1'b1;
                    ld_inst:    ld_req[i] = 1'b1;
                    store_inst: store_req[i] = 1'b1;
                    br_inst:    br_req[i] = 1'b1;
                    default:    ;
                endcase
            end
        end
    end

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(num_fu_alu)) alu_sel (
        .inst_req(alu_req), .fu_busy(fu_alu_busy), .fu_issued_insts(alu_bus),
        .num_issued(), .all_issued(alu_all)
    );

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(num_fu_mult)) mult_sel (
        .inst_req(mult_req), .fu_busy(fu_mult_busy), .fu_issued_insts(mult_bus),
        .num_issued(), .all_issued(mult_all)
    );

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(num_fu_ld)) ld_sel (
        .inst_req(ld_req), .fu_busy(fu_ld_busy), .fu_issued_insts(ld_bus),
        .num_issued(), .all_issued(ld_all)
    );

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(num_fu_store)) store_sel (
        .inst_req(store_req), .fu_busy(fu_store_busy), .fu_issued_insts(store_bus),
        .num_issued(), .all_issued(store_all)
    );

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(num_fu_br)) br_sel (
        .inst_req(br_req), .fu_busy(fu_br_busy), .fu_issued_insts(br_bus),
        .num_issued(), .all_issued(br_all)
    );

    assign all_issued = alu_all | mult_all | ld_all | store_all | br_all;

    for (genvar u = 0; u < num_fu_alu; u++) begin : g_alu
        assign issued_alu[u] = issue_pick(alu_bus[u], entries, br_id, br_task);
    end
    for (genvar u = 0; u < num_fu_mult; u++) begin : g_mult
        assign issued_mult[u] = issue_pick(mult_bus[u], entries, br_id, br_task);
    end
    for (genvar u = 0; u < num_fu_ld; u++) begin : g_ld
        assign issued_ld[u] = issue_pick(ld_bus[u], entries, br_id, br_task);
    end
    for (genvar u = 0; u < num_fu_store; u++) begin : g_store
        assign issued_store[u] = issue_pick(store_bus[u], entries, br_id, br_task);
    end
    for (genvar u = 0; u < num_fu_br; u++) begin : g_br
        assign issued_br[u] = issue_pick(br_bus[u], entries, br_id, br_task);
    end

    // Slots issuing or squashed now can be refilled at this edge
    assign free_slots = ~valid_vec | all_issued | squash_hit;

    psel_gen #(.WIDTH(DEPTH), .REQS(N)) slot_alloc (
        .req     (free_slots),
        .gnt_bus (alloc_bus),
        .gnt     (alloc_gnt),
        .empty   ()
    );

    always_comb begin
        num_occupied = CNT_W'($countones(valid_vec));
        num_empty = CNT_W'(DEPTH) - num_occupied;
        if (num_empty > CNT_W'(N)) begin
            open_entries = ACC_W'(N);
        end else begin
            open_entries = ACC_W'(num_empty);
        end
    end

    always_comb begin
        int k;
        next_entries = entries;
        k = 0;
        for (int j = 0; j < DEPTH; j++) begin
            if (all_issued[j] || squash_hit[j]) begin
                next_entries[j].valid = 1'b0;
            end
            // Wakeup from any CDB lane
            for (int c = 0; c < N; c++) begin
                if (cdb_in[c].valid && entries[j].src1.tag == cdb_in[c].tag) begin
                    next_entries[j].src1.ready = 1'b1;
                end
                if (cdb_in[c].valid && entries[j].src2.tag == cdb_in[c].tag) begin
                    next_entries[j].src2.ready = 1'b1;
                end
            end
            if (br_task == br_clear) begin
                next_entries[j].br_mask = entries[j].br_mask & ~br_id;
            end
        end
        for (int i = 0; i < N; i++) begin
            if (admitted[i].valid) begin
                for (int j = 0; j < DEPTH; j++) begin
                    if (alloc_bus[k][j]) begin
                        next_entries[j] = rs_packet_t'(admitted[i]);
                    end
                end
                k++;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= next_entries;
        end
    end

    accept_within_room: assert property (@(posedge clock) disable iff (reset)
        num_accept <= open_entries);

    // Admission never outruns the slots the allocator can hand out
    admit_has_slot: assert property (@(posedge clock) disable iff (reset)
        $countones(alloc_gnt) >= num_accept);

endmodule

/* hw/rs_top.sv */
`timescale 1ns/100ps

module rs_top
    import rs_pkg::*;
#(
    parameter int DEPTH = default_rs_depth,
    parameter int N     = default_dispatch_width
) (
    input  logic                              clock,
    input  logic                              reset,
    input  dispatch_packet_t [N-1:0]          dispatch_in,
    input  cdb_packet_t [N-1:0]               cdb_in,
    input  br_mask_t                          br_id,
    input  br_task_t                          br_task,
    input  logic [num_fu_alu-1:0]             fu_alu_busy,
    input  logic [num_fu_mult-1:0]            fu_mult_busy,
    input  logic [num_fu_ld-1:0]              fu_ld_busy,
    input  logic [num_fu_store-1:0]           fu_store_busy,
    input  logic [num_fu_br-1:0]              fu_br_busy,
    output rs_packet_t [num_fu_alu-1:0]       issued_alu,
    output rs_packet_t [num_fu_mult-1:0]      issued_mult,
    output rs_packet_t [num_fu_ld-1:0]        issued_ld,
    output rs_packet_t [num_fu_store-1:0]     issued_store,
    output rs_packet_t [num_fu_br-1:0]        issued_br,
    output logic [$clog2(N+1)-1:0]            num_accept
);

    dispatch_packet_t [N-1:0]      admitted;
    logic [$clog2(N+1)-1:0]        open_entries;

    dispatch_admit #(.N(N)) u_admit (
        .dispatch_in  (dispatch_in),
        .open_entries (open_entries),
        .admitted     (admitted),
        .num_accept   (num_accept)
    );

    rs #(.DEPTH(DEPTH), .N(N)) u_rs (
        .clock         (clock),
        .reset         (reset),
        .admitted      (admitted),
        .num_accept    (num_accept),
        .cdb_in        (cdb_in),
        .br_id         (br_id),
        .br_task       (br_task),
        .fu_alu_busy   (fu_alu_busy),
        .fu_mult_busy  (fu_mult_busy),
        .fu_ld_busy    (fu_ld_busy),
        .fu_store_busy (fu_store_busy),
        .fu_br_busy    (fu_br_busy),
        .issued_alu    (issued_alu),
        .issued_mult   (issued_mult),
        .issued_ld     (issued_ld),
        .issued_store  (issued_store),
        .issued_br     (issued_br),
        .open_entries  (open_entries)
    );

endmodule

/* verification/tb_rs_top.sv */
`timescale 1ns/100ps

module tb_rs_top
    import rs_pkg::*;
;

    localparam int DEPTH = 8;
    localparam int N     = 2;
    localparam int NUM_FIELDS = 32;

    logic                         clock;
    logic                         reset;
    dispatch_packet_t [N-1:0]     dispatch_in;
    cdb_packet_t [N-1:0]          cdb_in;
    br_mask_t                     br_id;
    br_task_t                     br_task;
    logic [num_fu_alu-1:0]        fu_alu_busy;
    logic [num_fu_mult-1:0]       fu_mult_busy;
    logic [num_fu_ld-1:0]         fu_ld_busy;
    logic [num_fu_store-1:0]      fu_store_busy;
    logic [num_fu_br-1:0]         fu_br_busy;
    rs_packet_t [num_fu_alu-1:0]  issued_alu;
    rs_packet_t [num_fu_mult-1:0] issued_mult;
    rs_packet_t [num_fu_ld-1:0]   issued_ld;
    rs_packet_t [num_fu_store-1:0] issued_store;
    rs_packet_t [num_fu_br-1:0]   issued_br;
    logic [$clog2(N+1)-1:0]       num_accept;

    int total_errors;
    int test_errors;
    int tests_passed;
    int tests_failed;
    bit aborted;

    rs_top #(.DEPTH(DEPTH), .N(N)) u_rs_top (
        .clock         (clock),
        .reset         (reset),
        .dispatch_in   (dispatch_in),
        .cdb_in        (cdb_in),
        .br_id         (br_id),
        .br_task       (br_task),
        .fu_alu_busy   (fu_alu_busy),
        .fu_mult_busy  (fu_mult_busy),
        .fu_ld_busy    (fu_ld_busy),
        .fu_store_busy (fu_store_busy),
        .fu_br_busy    (fu_br_busy),
        .issued_alu    (issued_alu),
        .issued_mult   (issued_mult),
        .issued_ld     (issued_ld),
        .issued_store  (issued_store),
        .issued_br     (issued_br),
        .num_accept    (num_accept)
    );

    initial begin
        clock = 1'b0;
    end

    always #4 clock = ~clock;

    task automatic note_mismatch(input string name, input int exp, input int got);
        $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got);
        total_errors++;
        test_errors++;
    endtask

    // Expected code 0 means no instruction, otherwise the destination tag
    task automatic check_issue(input string name, input int exp, input rs_packet_t pkt);
        if (exp == 0 && pkt.valid !== 1'b0) begin
            note_mismatch({name, ".valid"}, 0, pkt.valid);
        end
        if (exp != 0 && pkt.valid !== 1'b1) begin
            note_mismatch({name, ".valid"}, 1, pkt.valid);
        end
        if (exp != 0 && pkt.dest_tag !== exp[preg_idx_width-1:0]) begin
            note_mismatch({name, ".dest_tag"}, exp, pkt.dest_tag);
        end
    endtask

    task automatic report_test(input int test_num);
        if (test_errors == 0) begin
            $display("Test %0d passed", test_num);
            tests_passed++;
        end else begin
            $display("Test %0d failed with %0d errors", test_num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic apply_line(input int f[NUM_FIELDS]);
        for (int s = 0; s < N; s++) begin
            dispatch_in[s].valid    = (f[1+7*s] != 0);
            dispatch_in[s].fu_type  = fu_type_t'(f[2+7*s]);
            dispatch_in[s].func     = 8'(f[1+7*s]);
            dispatch_in[s].dest_tag = f[1+7*s];
            dispatch_in[s].src1     = '{tag: f[3+7*s], ready: f[4+7*s]};
            dispatch_in[s].src2     = '{tag: f[5+7*s], ready: f[6+7*s]};
            dispatch_in[s].br_mask  = f[7+7*s];
            cdb_in[s].valid = (f[15+s] != 0);
            cdb_in[s].tag   = f[15+s];
        end
        br_id         = f[17];
        br_task       = br_task_t'(f[18]);
        fu_alu_busy   = f[19];
        fu_mult_busy  = f[20];
        fu_ld_busy    = f[21];
        fu_store_busy = f[22];
        fu_br_busy    = f[23];
    endtask

    task automatic check_line(input int f[NUM_FIELDS]);
        check_issue("issued_alu[0]", f[24], issued_alu[0]);
        check_issue("issued_alu[1]", f[25], issued_alu[1]);
        check_issue("issued_mult[0]", f[26], issued_mult[0]);
        check_issue("issued_ld[0]", f[27], issued_ld[0]);
        check_issue("issued_store[0]", f[28], issued_store[0]);
        check_issue("issued_br[0]", f[29], issued_br[0]);
        if (f[24] != 0 && issued_alu[0].br_mask !== f[30][br_mask_width-1:0]) begin
            note_mismatch("issued_alu[0].br_mask", f[30], issued_alu[0].br_mask);
        end
        if (num_accept !== f[31][$clog2(N+1)-1:0]) begin
            note_mismatch("num_accept", f[31], num_accept);
        end
    endtask

    task automatic run_file(input int fd);
        string line;
        int f[NUM_FIELDS];
        int line_count;
        int cur_test;
        int n;
        line_count = 0;
        cur_test = -1;
        while (!$feof(fd) && line_count < 1000) begin
            n = $fgets(line, fd);
            line_count++;
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
                f[24], f[25], f[26], f[27], f[28], f[29], f[30], f[31]);
            if (n != NUM_FIELDS) begin
                $display("Malformed stimulus line %0d, found %0d fields", line_count, n);
                total_errors++;
                continue;
            end
            if (cur_test != -1 && f[0] != cur_test) begin
                report_test(cur_test);
            end
            cur_test = f[0];
            @(posedge clock);
            #1;
            apply_line(f);
            #6;
            check_line(f);
        end
        if (!$feof(fd)) begin
            $display("Stimulus file still not finished after 1000 lines, giving up");
            aborted = 1'b1;
        end
        if (cur_test != -1) begin
            report_test(cur_test);
        end
    endtask

    initial begin
        int fd;
        int wait_cycles;
        total_errors = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted = 1'b0;
        reset = 1'b1;
        dispatch_in = '0;
        cdb_in = '0;
        br_id = '0;
        br_task = br_none;
        fu_alu_busy = '0;
        fu_mult_busy = '0;
        fu_ld_busy = '0;
        fu_store_busy = '0;
        fu_br_busy = '0;
        fork
            begin
                repeat (10) @(posedge clock);
                #1 reset = 1'b0;
            end
        join_none
        wait_cycles = 0;
        while (reset && wait_cycles < 20) begin
            @(posedge clock);
            wait_cycles++;
        end
        fd = $fopen("verification/rs_input.txt", "r");
        if (reset) begin
            $display("Reset never released within 20 cycles");
            aborted = 1'b1;
        end else if (fd == 0) begin
            $display("Could not open the stimulus file verification/rs_input.txt");
            aborted = 1'b1;
        end else begin
            run_file(fd);
            $fclose(fd);
        end
        $display("Tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0 && !aborted) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
hw/rs_pkg.sv
hw/psel_gen.sv
hw/rs_issue_select.sv
hw/dispatch_admit.sv
hw/rs.sv
hw/rs_top.sv
verification/tb_rs_top.sv

/* verification/rs_input.txt */
# test | per slot: dest fu s1tag s1rdy s2tag s2rdy mask (dest 0 = none) | cdb0 cdb1 br_id br_task
# busy alu mult ld st br | expect alu0 alu1 mult ld st br (0 = none, else dest) alu0_mask num_accept
1  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 0
1  10 0 0 1 0 1 0  11 1 0 1 0 1 0  0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 2
1  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   10 0 11 0 0 0 0 0
1  12 2 0 1 0 1 0  14 3 0 1 0 1 0  0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 2
1  13 4 0 1 0 1 0  0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   0 0 0 12 14 0 0 1
1  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   0 0 0 0 0 13 0 0
2  20 0 5 0 6 1 0  0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 1
2  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 0
2  0 0 0 0 0 0 0   0 0 0 0 0 0 0   5 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 0
2  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   20 0 0 0 0 0 0 0
3  31 0 30 0 0 1 0 32 0 30 0 0 1 0 0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 2
3  33 0 30 0 0 1 0 34 0 30 0 0 1 0 0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 2
3  35 0 30 0 0 1 0 36 0 30 0 0 1 0 0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 2
3  37 0 30 0 0 1 0 0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 1
3  38 0 30 0 0 1 0 39 0 30 0 0 1 0 0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 1
3  40 0 30 0 0 1 0 41 0 30 0 0 1 0 0 0 0 0  0 0 0 0 0   0 0 0 0 0 0 0 0
3  0 0 0 0 0 0 0   0 0 0 0 0 0 0   30 0 0 0 0 0 0 0 0   0 0 0 0 0 0 0 0
3  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   31 32 0 0 0 0 0 0
3  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   33 34 0 0 0 0 0 0
3  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   35 36 0 0 0 0 0 0
3  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   37 38 0 0 0 0 0 0
4  50 0 0 1 0 1 0  51 0 0 1 0 1 0  0 0 0 0  1 0 0 0 0   0 0 0 0 0 0 0 2
4  52 1 0 1 0 1 0  0 0 0 0 0 0 0   0 0 0 0  1 1 0 0 0   0 50 0 0 0 0 0 1
4  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  1 1 0 0 0   0 51 0 0 0 0 0 0
4  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 1 0 0 0   0 0 0 0 0 0 0 0
4  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   0 0 52 0 0 0 0 0
5  60 0 0 1 0 1 1  61 0 0 1 0 1 2  0 0 0 0  3 0 0 0 0   0 0 0 0 0 0 0 2
5  62 0 0 1 0 1 1  63 0 0 1 0 1 1  0 0 0 0  3 0 0 0 0   0 0 0 0 0 0 0 2
5  64 0 0 1 0 1 1  65 0 0 1 0 1 1  0 0 0 0  3 0 0 0 0   0 0 0 0 0 0 0 2
5  66 0 0 1 0 1 1  67 0 0 1 0 1 1  0 0 0 0  3 0 0 0 0   0 0 0 0 0 0 0 2
5  70 0 0 1 0 1 0  0 0 0 0 0 0 0   0 0 1 2  2 0 0 0 0   0 0 0 0 0 0 0 0
5  70 0 0 1 0 1 0  71 0 0 1 0 1 0  0 0 0 0  3 0 0 0 0   0 0 0 0 0 0 0 2
5  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   70 61 0 0 0 0 0 0
5  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   71 0 0 0 0 0 0 0
6  80 0 0 1 0 1 5  0 0 0 0 0 0 0   0 0 0 0  3 0 0 0 0   0 0 0 0 0 0 0 1
6  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 4 1  3 0 0 0 0   0 0 0 0 0 0 0 0
6  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0  0 0 0 0 0   80 0 0 0 0 0 1 0
6  81 0 0 1 0 1 3  0 0 0 0 0 0 0   0 0 0 0  3 0 0 0 0   0 0 0 0 0 0 0 1
6  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 2 1  0 0 0 0 0   81 0 0 0 0 0 1 0
